//--- list.f
+incdir+include
hdl/spi_bus_pkg.sv
hdl/periph_pkg.sv
hdl/spi_pin_sync.sv
hdl/spi_bit_counter.sv
hdl/spi_frame_fsm.sv
hdl/spi_shift_register.sv
hdl/register_bank.sv
hdl/spi_register_target.sv
verif/spi_register_target_sva.sv
verif/spi_register_target_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= spi_register_target_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the testbench printed the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/spi_register_target_tb.sv
// SPI register target testbench that runs host frames and checks them against a register model
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module spi_register_target_tb;

    import periph_pkg::*;

    // SCK half period in system cycles
    localparam int half_sck = 8;
    localparam int max_len = 16;
    localparam int frame_count = 40;
    // Worst case frame is the address byte plus max_len data bytes and the idle gaps
    localparam int frame_cycles = 2 * half_sck * `SPI_BYTE_BITS * (max_len + 1) + 4 * half_sck;
    localparam int timeout_ns = (frame_count * frame_cycles + 500) * 40;

    logic         spi_address_valid = 1'b0;
    logic         rst;
    logic         spi_clock;
    logic         spi_select;
    logic         spi_data_in;
    logic         spi_data_out;
    write_event_t write_event;

    // Reference register model and host bookkeeping
    byte_t        ref_regs [`REG_COUNT];
    byte_t        frame_data [$];
    write_event_t exp_events [$];
    write_event_t next_event;
    integer       seed = 32'hef44_8bda;
    logic [31:0]  rnd;
    reg_addr_t    rnd_start;
    int           rnd_len;
    int           value_errors = 0;
    int           other_errors = 0;

    spi_register_target i_spi_register_target (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .spi_clock         (spi_clock),
        .spi_select        (spi_select),
        .spi_data_in       (spi_data_in),
        .spi_data_out      (spi_data_out),
        .write_event       (write_event)
    );

    // 40 ns system clock
    always #20 spi_address_valid = ~spi_address_valid;

    // Step n rising edges, then move to the drive point
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge spi_address_valid);
        #2;
    endtask

    // Expected MISO byte where unmapped addresses read zero
    function automatic byte_t expected_read(input reg_addr_t addr);
        if (addr < reg_addr_t'(`REG_COUNT)) begin
            return ref_regs[addr[$bits(reg_index_t)-1:0]];
        end else begin
            return '0;
        end
    endfunction

    // Mode 0 host sending MSB first and taking MISO at each rising SCK
    task automatic shift_byte(input byte_t value, input int bits, output byte_t got);
        got = '0;
        for (int i = `SPI_BYTE_BITS - 1; i >= `SPI_BYTE_BITS - bits; i--) begin
            spi_data_in = value[i];
            wait_cycles(half_sck);
            got[i] = spi_data_out;
            spi_clock = 1'b1;
            wait_cycles(half_sck);
            spi_clock = 1'b0;
        end
    endtask

    task automatic random_data(input int n);
        frame_data.delete();
        repeat (n) begin
            frame_data.push_back(byte_t'($random(seed)));
        end
    endtask

    // Address byte, all of frame_data, then an optional partial byte before select rises
    task automatic run_frame(input logic write, input reg_addr_t start, input int partial_bits);
        reg_addr_t    addr;
        byte_t        expected;
        byte_t        got;
        write_event_t ev;
        addr = start;
        spi_select = 1'b0;
        shift_byte({write, start}, `SPI_BYTE_BITS, got);
        foreach (frame_data[k]) begin
            // MISO carries the old contents since the write lands after the byte
            expected = expected_read(addr);
            if (write && addr < reg_addr_t'(`REG_COUNT)) begin
                ev.valid = 1'b1;
                ev.addr  = addr;
                ev.data  = frame_data[k];
                exp_events.push_back(ev);
                ref_regs[addr[$bits(reg_index_t)-1:0]] = frame_data[k];
            end
            shift_byte(frame_data[k], `SPI_BYTE_BITS, got);
            if (got !== expected) begin
                $display("ERROR t=%0t spi_data_out at address %0d: got %h expected %h",
                         $time, addr, got, expected);
                value_errors++;
            end
            addr = addr + 1'b1;
        end
        if (partial_bits > 0) begin
            shift_byte(byte_t'($random(seed)), partial_bits, got);
        end
        wait_cycles(half_sck);
        spi_select = 1'b1;
        wait_cycles(2 * half_sck);
        if (exp_events.size() != 0) begin
            $display("%0d write events missing after the frame at address %0d",
                     exp_events.size(), start);
            other_errors++;
            exp_events.delete();
        end
    endtask

    // Write events checked in order against the expected queue and sampled mid-cycle
    always @(negedge spi_address_valid) begin
        if (!rst && write_event.valid === 1'b1) begin
            if (exp_events.size() == 0) begin
                $display("Unexpected write event at t=%0t to address %0d",
                         $time, write_event.addr);
                other_errors++;
            end else begin
                next_event = exp_events.pop_front();
                if (write_event.addr !== next_event.addr) begin
                    $display("ERROR t=%0t write_event.addr: got %0d expected %0d",
                             $time, write_event.addr, next_event.addr);
                    value_errors++;
                end
                if (write_event.data !== next_event.data) begin
                    $display("ERROR t=%0t write_event.data: got %h expected %h",
                             $time, write_event.data, next_event.data);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        spi_clock = 1'b0;
        spi_select = 1'b1;
        spi_data_in = 1'b0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = `REG_RESET_VALUE;
        end
        wait_cycles(2);
        rst = 1'b0;
        wait_cycles(half_sck);
        // Quiet outputs after reset
        if (spi_data_out !== 1'b0) begin
            $display("ERROR t=%0t spi_data_out: got %b expected 0", $time, spi_data_out);
            value_errors++;
        end
        if (write_event.valid !== 1'b0) begin
            $display("ERROR t=%0t write_event.valid: got %b expected 0",
                     $time, write_event.valid);
            value_errors++;
        end
        random_data(16);
        run_frame(1'b0, 7'd0, 0);
        // Single write and read back
        random_data(1);
        run_frame(1'b1, 7'd9, 0);
        run_frame(1'b0, 7'd9, 0);
        // Burst over 3 to 8
        random_data(6);
        run_frame(1'b1, 7'd3, 0);
        run_frame(1'b0, 7'd3, 0);
        // Crossing into the unmapped range, then the low registers
        random_data(5);
        run_frame(1'b1, 7'd14, 0);
        run_frame(1'b0, 7'd14, 0);
        random_data(4);
        run_frame(1'b0, 7'd0, 0);
        // Select rises 5 bits into the byte for address 6
        random_data(1);
        run_frame(1'b1, 7'd5, 5);
        random_data(2);
        run_frame(1'b0, 7'd5, 0);
        for (int f = 0; f < 30; f++) begin
            rnd = $random(seed);
            // Low addresses favoured so that most frames hit registers
            rnd_start = rnd[7] ? {3'b000, rnd[3:0]} : rnd[6:0];
            rnd_len = 1 + int'(rnd[10:8]);
            if (f == 0) begin
                // Crosses 127 to 0 as a write so the wrapped addresses raise events
                rnd_start = 7'd126;
                rnd_len = 4;
                rnd[11] = 1'b1;
            end
            random_data(rnd_len);
            run_frame(rnd[11], rnd_start, 0);
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ends a hung run
    initial begin
        #(timeout_ns);
        $display("Timeout, the tests did not finish within %0d ns", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verif/spi_register_target_sva.sv
// Port assertions for the SPI register target, bound into every instance of the top level
`timescale 1ns/1ps

module spi_register_target_sva (
    input logic spi_address_valid,
    input logic rst,
    input logic spi_select,
    input logic spi_data_out,
    input logic write_valid
);

    // Write strobe is a single-cycle pulse
    single_write_pulse: assert property (@(posedge spi_address_valid) disable iff (rst)
        write_valid |=> !write_valid)
        else $error("write_event.valid high for two cycles in a row");

    // Writes only inside a frame that has been open for a while
    write_inside_frame: assert property (@(posedge spi_address_valid) disable iff (rst)
        write_valid |-> (!spi_select && !$past(spi_select) && !$past(spi_select, 2)))
        else $error("write_event.valid without select held low for 3 cycles");

    // Synchronizer latency is 3 cycles, so the fourth sample sees a quiet MISO
    quiet_miso: assert property (@(posedge spi_address_valid) disable iff (rst)
        (spi_select && $past(spi_select) && $past(spi_select, 2) && $past(spi_select, 3))
        |-> !spi_data_out)
        else $error("spi_data_out high while select is released");

endmodule

bind spi_register_target spi_register_target_sva i_spi_register_target_sva (
    .spi_address_valid (spi_address_valid),
    .rst               (rst),
    .spi_select        (spi_select),
    .spi_data_out      (spi_data_out),
    .write_valid       (write_event.valid)
);

//--- hdl/spi_register_target.sv
// Top level of the SPI register target, wires the pin front end to the register bank
`timescale 1ns/1ps

module spi_register_target (
    input  logic                     spi_address_valid,
    input  logic                     rst,
    input  logic                     spi_clock,
    input  logic                     spi_select,
    input  logic                     spi_data_in,
    output logic                     spi_data_out,
    output periph_pkg::write_event_t write_event
);

    import spi_bus_pkg::*;
    import periph_pkg::*;

    spi_events_t events;
    bit_index_t  bit_index;
    logic        byte_done;
    logic        load_tx;
    reg_addr_t   read_addr;
    byte_t       read_data;
    byte_t       rx_byte;

    // Pin synchronizers and edge detect
    spi_pin_sync i_spi_pin_sync (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .spi_clock         (spi_clock),
        .spi_select        (spi_select),
        .spi_data_in       (spi_data_in),
        .events            (events)
    );

    spi_bit_counter i_spi_bit_counter (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .events            (events),
        .bit_index         (bit_index),
        .byte_done         (byte_done)
    );

    // Address decode and write strobes
    spi_frame_fsm i_spi_frame_fsm (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .events            (events),
        .byte_done         (byte_done),
        .rx_byte           (rx_byte),
        .read_addr         (read_addr),
        .load_tx           (load_tx),
        .write_event       (write_event)
    );

    spi_shift_register i_spi_shift_register (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .events            (events),
        .bit_index         (bit_index),
        .load_tx           (load_tx),
        .read_data         (read_data),
        .rx_byte           (rx_byte),
        .spi_data_out      (spi_data_out)
    );

    // Bank sees the same strobe as the output port
    register_bank i_register_bank (
        .spi_address_valid (spi_address_valid),
        .rst               (rst),
        .write_event       (write_event),
        .read_addr         (read_addr),
        .read_data         (read_data)
    );

endmodule

//--- hdl/register_bank.sv
// Bank of mapped byte registers written by write strobes and read combinationally
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module register_bank (
    input  logic                     spi_address_valid,
    input  logic                     rst,
    input  periph_pkg::write_event_t write_event,
    input  periph_pkg::reg_addr_t    read_addr,
    output periph_pkg::byte_t        read_data
);

    import periph_pkg::*;

    byte_t      regs [`REG_COUNT];
    reg_index_t wr_index;
    reg_index_t rd_index;

    // Low address bits select the register
    assign wr_index = write_event.addr[$bits(reg_index_t)-1:0];
    assign rd_index = read_addr[$bits(reg_index_t)-1:0];

    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= `REG_RESET_VALUE;
            end
        end else if (write_event.valid) begin
            // FSM only strobes mapped addresses
            regs[wr_index] <= write_event.data;
        end
    end

    // Unmapped addresses read as zero
    assign read_data = (read_addr < reg_addr_t'(`REG_COUNT)) ? regs[rd_index] : '0;

endmodule

//--- hdl/spi_shift_register.sv
// Receive and transmit shift registers of the target, MSB first in SPI mode 0
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module spi_shift_register (
    input  logic                     spi_address_valid,
    input  logic                     rst,
    input  spi_bus_pkg::spi_events_t events,
    input  spi_bus_pkg::bit_index_t  bit_index,
    input  logic                     load_tx,
    input  periph_pkg::byte_t        read_data,
    output periph_pkg::byte_t        rx_byte,
    output logic                     spi_data_out
);

    import spi_bus_pkg::*;
    import periph_pkg::*;

    localparam bit_index_t msb_index = bit_index_t'(`SPI_BYTE_BITS - 1);

    byte_t rx_shift;
    byte_t tx_shift;

    // Sample MOSI on each rising SCK
    always_ff @(posedge spi_address_valid) begin
        if (events.sck_rise && events.selected) begin
            rx_shift <= {rx_shift[`SPI_BYTE_BITS-2:0], events.mosi};
        end
    end

    // Includes the bit being sampled, complete in the byte_done cycle
    assign rx_byte = {rx_shift[`SPI_BYTE_BITS-2:0], events.mosi};

    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            tx_shift <= '0;
        end else if (events.sel_fall) begin
            // Zeros go out during the address byte
            tx_shift <= '0;
        end else if (load_tx) begin
            tx_shift <= read_data;
        end else if (events.sck_fall && events.selected && bit_index != msb_index) begin
            // The fall at a byte boundary keeps the freshly loaded MSB
            tx_shift <= {tx_shift[`SPI_BYTE_BITS-2:0], 1'b0};
        end
    end

    // Quiet line outside a frame
    assign spi_data_out = events.selected & tx_shift[`SPI_BYTE_BITS-1];

endmodule

//--- hdl/spi_frame_fsm.sv
// Frame FSM of the target: decodes the address byte, steps the address and strobes writes
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module spi_frame_fsm (
    input  logic                      spi_address_valid,
    input  logic                      rst,
    input  spi_bus_pkg::spi_events_t  events,
    input  logic                      byte_done,
    input  periph_pkg::byte_t         rx_byte,
    output periph_pkg::reg_addr_t     read_addr,
    output logic                      load_tx,
    output periph_pkg::write_event_t  write_event
);

    import spi_bus_pkg::*;
    import periph_pkg::*;

    frame_phase_e phase;
    reg_addr_t    addr_cnt;
    logic         write_flag;
    logic         mapped;
    logic         wr_valid;
    reg_addr_t    wr_addr;
    byte_t        wr_data;

    // Only the low addresses hold registers
    assign mapped    = addr_cnt < reg_addr_t'(`REG_COUNT);
    assign read_addr = addr_cnt;

    // Phase, address counter, write flag and strobes
    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            phase      <= IDLE;
            addr_cnt   <= '0;
            write_flag <= 1'b0;
            load_tx    <= 1'b0;
            wr_valid   <= 1'b0;
        end else begin
            load_tx  <= 1'b0;
            wr_valid <= 1'b0;
            if (events.sel_rise) begin
                // Abort, a partial byte is simply dropped
                phase <= IDLE;
            end else if (events.sel_fall) begin
                phase <= ADDRESS;
            end else if (byte_done) begin
                case (phase)
                    ADDRESS: begin
                        phase      <= DATA;
                        write_flag <= rx_byte[`SPI_BYTE_BITS-1];
                        addr_cnt   <= rx_byte[`SPI_BYTE_BITS-2:0];
                        load_tx    <= 1'b1;
                    end
                    DATA: begin
                        wr_valid <= write_flag & mapped;
                        // Wraps inside 7 bits
                        addr_cnt <= addr_cnt + 1'b1;
                        // Fetch the register at the next address
                        load_tx  <= 1'b1;
                    end
                    default: begin
                        phase <= IDLE;
                    end
                endcase
            end
        end
    end

    // Write payload captured with the byte it belongs to
    always_ff @(posedge spi_address_valid) begin
        if (byte_done && phase == DATA) begin
            wr_addr <= addr_cnt;
            wr_data <= rx_byte;
        end
    end

    assign write_event = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

//--- hdl/spi_bit_counter.sv
// Tracks the bit position inside the current SPI byte and flags each completed byte
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module spi_bit_counter (
    input  logic                     spi_address_valid,
    input  logic                     rst,
    input  spi_bus_pkg::spi_events_t events,
    output spi_bus_pkg::bit_index_t  bit_index,
    output logic                     byte_done
);

    import spi_bus_pkg::*;

    // MSB goes first, so counting starts at the top
    localparam bit_index_t msb_index = bit_index_t'(`SPI_BYTE_BITS - 1);

    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            bit_index <= msb_index;
        end else if (events.sel_fall) begin
            // New frame always starts on a byte boundary
            bit_index <= msb_index;
        end else if (events.sck_rise && events.selected) begin
            // Roll over to the next byte after bit 0
            if (bit_index == '0) begin
                bit_index <= msb_index;
            end else begin
                bit_index <= bit_index - 1'b1;
            end
        end
    end

    // Same cycle as the rise that samples bit 0
    assign byte_done = events.sck_rise & events.selected & (bit_index == '0);

endmodule

//--- hdl/spi_pin_sync.sv
// Oversamples SCK, select and MOSI with the system clock and produces edge event pulses
`timescale 1ns/1ps
`include "spi_target_consts.svh"

module spi_pin_sync (
    input  logic                    spi_address_valid,
    input  logic                    rst,
    input  logic                    spi_clock,
    input  logic                    spi_select,
    input  logic                    spi_data_in,
    output spi_bus_pkg::spi_events_t events
);

    // Last stage of each chain
    localparam int last = `SPI_SYNC_STAGES - 1;

    logic [`SPI_SYNC_STAGES-1:0] sck_sync;
    logic [`SPI_SYNC_STAGES-1:0] sel_sync;
    logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
    logic                        sck_prev;
    logic                        sel_prev;

    // Synchronizer chains, select idles high so no false frame start
    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            sck_sync <= '0;
            sel_sync <= '1;
        end else begin
            sck_sync <= {sck_sync[`SPI_SYNC_STAGES-2:0], spi_clock};
            sel_sync <= {sel_sync[`SPI_SYNC_STAGES-2:0], spi_select};
        end
    end

    // MOSI takes the same path length as SCK
    always_ff @(posedge spi_address_valid) begin
        mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], spi_data_in};
    end

    // Registered edge detect, third cycle after the pin edge
    always_ff @(posedge spi_address_valid) begin
        if (rst) begin
            sck_prev <= 1'b0;
            sel_prev <= 1'b1;
            events   <= '0;
        end else begin
            sck_prev        <= sck_sync[last];
            sel_prev        <= sel_sync[last];
            events.sck_rise <= sck_sync[last] & ~sck_prev;
            events.sck_fall <= ~sck_sync[last] & sck_prev;
            events.sel_fall <= ~sel_sync[last] & sel_prev;
            events.sel_rise <= sel_sync[last] & ~sel_prev;
            // Select is active low
            events.selected <= ~sel_sync[last];
            events.mosi     <= mosi_sync[last];
        end
    end

endmodule

//--- hdl/periph_pkg.sv
// Types on the register side of the target, shared by FSM, shifter, bank and top level
`include "spi_target_consts.svh"

package periph_pkg;

    // Register data, one SPI byte
    typedef logic [`SPI_BYTE_BITS-1:0] byte_t;

    // Address from the address byte, the MSB is the write flag
    typedef logic [`SPI_BYTE_BITS-2:0] reg_addr_t;

    // Index into the mapped registers
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_index_t;

    // Strobe for one register write, fields valid only with valid high
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        byte_t     data;
    } write_event_t;

endpackage

//--- hdl/spi_bus_pkg.sv
// Types on the SPI side of the target, shared by synchronizer, counter, FSM and shifter
`include "spi_target_consts.svh"

package spi_bus_pkg;

    // Position of a bit inside a byte, 7 is the MSB
    typedef logic [$clog2(`SPI_BYTE_BITS)-1:0] bit_index_t;

    // Pin activity seen from the system clock
    typedef struct packed {
        // One-cycle pulses on SCK edges
        logic sck_rise;
        logic sck_fall;
        // One-cycle pulses on select edges
        logic sel_fall;
        logic sel_rise;
        // Level, high while select is low
        logic selected;
        // MOSI aligned with the SCK events
        logic mosi;
    } spi_events_t;

    // Where the frame currently is
    typedef enum logic [1:0] {
        IDLE,
        ADDRESS,
        DATA
    } frame_phase_e;

endpackage

//--- include/spi_target_consts.svh
// Fixed sizes and reset values of the SPI register target, included by RTL and testbench
`ifndef SPI_TARGET_CONSTS_SVH
`define SPI_TARGET_CONSTS_SVH

// Bits per SPI byte, MSB first on the wire
`define SPI_BYTE_BITS 8

// Flip-flops in each pin synchronizer chain
`define SPI_SYNC_STAGES 2

// Mapped registers starting at address 0
`define REG_COUNT 16

// Register contents after reset
`define REG_RESET_VALUE 8'h00

`endif
